// ==== design/masked_pwm_pkg.sv ====
/* masked pointwise multiply, shared constants */

`default_nettype none

package masked_pwm_pkg;

    // default modulus, ml-dsa prime
    parameter int unsigned DEFAULT_Q = 32'd8380417;

    // coefficient width, one bit of headroom over q
    parameter int DEFAULT_COEFF_W = 24;

    // arithmetic shares per coefficient
    parameter int NUM_SHARES = 2;

    // register stages through the barrett reducer
    parameter int BARRETT_LAT = 2;

    // cross products, share sums, then barrett
    parameter int MULT_LAT = 2 + BARRETT_LAT;

    // masked adder has a single output register
    parameter int ADD_LAT = 1;

    // end to end latency, multiply mode
    parameter int PWM_LAT = MULT_LAT;

    // accumulate mode adds the product/w capture stage and the adder
    parameter int PWMA_LAT = MULT_LAT + 1 + ADD_LAT;

endpackage

`default_nettype wire

// ==== design/mult_if.sv ====
/* masked multiplier link */

`timescale 1ns/1ps
`default_nettype none

interface mult_if import masked_pwm_pkg::*; #(
    parameter int COEFF_W = DEFAULT_COEFF_W
);

    // operand shares
    logic [NUM_SHARES-1:0][COEFF_W-1:0] a_share;
    logic [NUM_SHARES-1:0][COEFF_W-1:0] b_share;

    // fresh mask for the product, below q
    logic [COEFF_W-1:0] refresh;

    // re-masked product shares
    logic [NUM_SHARES-1:0][COEFF_W-1:0] prod_share;

    // pwm side
    modport requester (
        output a_share,
        output b_share,
        output refresh,
        input  prod_share
    );

    // multiplier side
    modport multiplier (
        input  a_share,
        input  b_share,
        input  refresh,
        output prod_share
    );

endinterface

`default_nettype wire

// ==== design/barrett_reduce.sv ====
/* pipelined barrett reduction */

`timescale 1ns/1ps
`default_nettype none

module barrett_reduce import masked_pwm_pkg::*; #(
    parameter int unsigned REDUCE_Q = DEFAULT_Q,
    parameter int          COEFF_W  = DEFAULT_COEFF_W
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize,
    input  logic [2*COEFF_W-1:0] x,
    output logic [COEFF_W-1:0]   r
);

    localparam int XW = 2*COEFF_W;
    localparam int K  = $clog2(REDUCE_Q);
    // drop the low k-1 bits before the multiply
    localparam int SH = K - 1;
    localparam int MW = XW - SH;
    // m = floor(2^xw / q), fits in mw bits since q > 2^(k-1)
    localparam logic [63:0]    M_FULL    = (64'd1 << XW) / 64'(REDUCE_Q);
    localparam logic [MW-1:0]  BARRETT_M = M_FULL[MW-1:0];
    localparam logic [XW-1:0]  Q_X       = XW'(REDUCE_Q);

    logic [MW-1:0]   x_hi;
    logic [2*MW-1:0] qprod;
    logic [MW-1:0]   qest_q;
    logic [XW-1:0]   x_q;
    logic [XW-1:0]   rem0;
    logic [XW-1:0]   rem1;
    logic [XW-1:0]   rem2;

    // stage 1 quotient estimate, never above floor(x/q)
    assign x_hi  = x[XW-1:SH];
    assign qprod = x_hi * BARRETT_M;

    // stage 2 remainder, below 3q before correction
    assign rem0 = x_q - ({{(XW-MW){1'b0}}, qest_q} * Q_X);
    assign rem1 = (rem0 >= Q_X) ? rem0 - Q_X : rem0;
    assign rem2 = (rem1 >= Q_X) ? rem1 - Q_X : rem1;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            x_q    <= '0;
            qest_q <= '0;
            r      <= '0;
        end else if (zeroize) begin
            x_q    <= '0;
            qest_q <= '0;
            r      <= '0;
        end else begin
            // estimate travels with its own input
            x_q    <= x;
            qest_q <= qprod[2*MW-1:MW];
            // result below q, upper bits are zero
            r      <= rem2[COEFF_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/masked_mult.sv ====
/* masked share multiplier */

`timescale 1ns/1ps
`default_nettype none

module masked_mult import masked_pwm_pkg::*; #(
    parameter int unsigned REDUCE_Q = DEFAULT_Q,
    parameter int          COEFF_W  = DEFAULT_COEFF_W
) (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize,
    mult_if.multiplier bus
);

    localparam int PW = 2*COEFF_W;
    localparam logic [PW-1:0] Q_P = PW'(REDUCE_Q);

    // cross products, index [share of a][share of b]
    logic [NUM_SHARES-1:0][NUM_SHARES-1:0][PW-1:0] xprod_q;
    logic [COEFF_W-1:0]                            refresh_q;

    // unreduced share sums
    logic [NUM_SHARES-1:0][PW-1:0] share_sum_q;
    logic [NUM_SHARES-1:0][PW-1:0] share_sum;

    // reduced shares out of barrett
    logic [NUM_SHARES-1:0][COEFF_W-1:0] share_red;

    // stage 1: all four partial products
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            xprod_q   <= '0;
            refresh_q <= '0;
        end else if (zeroize) begin
            xprod_q   <= '0;
            refresh_q <= '0;
        end else begin
            for (int i = 0; i < NUM_SHARES; i++) begin
                for (int j = 0; j < NUM_SHARES; j++) begin
                    xprod_q[i][j] <= {{COEFF_W{1'b0}}, bus.a_share[i]} *
                                     {{COEFF_W{1'b0}}, bus.b_share[j]};
                end
            end
            // mask is consumed one stage later
            refresh_q <= bus.refresh;
        end
    end

    // share 0 takes u0 row plus mask
    assign share_sum[0] = xprod_q[0][0] + xprod_q[0][1] + {{COEFF_W{1'b0}}, refresh_q};
    // share 1 takes u1 row minus mask, +q keeps it positive
    assign share_sum[1] = xprod_q[1][0] + xprod_q[1][1] + Q_P
                          - {{COEFF_W{1'b0}}, refresh_q};

    // stage 2: refreshed sums
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            share_sum_q <= '0;
        end else if (zeroize) begin
            share_sum_q <= '0;
        end else begin
            share_sum_q <= share_sum;
        end
    end

    // stages 3 and 4: one reducer per share
    for (genvar g = 0; g < NUM_SHARES; g++) begin : g_reduce
        barrett_reduce #(
            .REDUCE_Q (REDUCE_Q),
            .COEFF_W  (COEFF_W)
        ) i_barrett (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .x       (share_sum_q[g]),
            .r       (share_red[g])
        );
    end

    // shares recombine to u*v mod q
    assign bus.prod_share = share_red;

endmodule

`default_nettype wire

// ==== design/masked_add.sv ====
/* masked modular adder */

`timescale 1ns/1ps
`default_nettype none

module masked_add import masked_pwm_pkg::*; #(
    parameter int unsigned REDUCE_Q = DEFAULT_Q,
    parameter int          COEFF_W  = DEFAULT_COEFF_W
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize,
    input  logic [NUM_SHARES-1:0][COEFF_W-1:0] a,
    input  logic [NUM_SHARES-1:0][COEFF_W-1:0] b,
    input  logic [COEFF_W-1:0]                 rnd,
    output logic [NUM_SHARES-1:0][COEFF_W-1:0] res
);

    localparam int SW = COEFF_W + 2;
    localparam logic [SW-1:0] Q_S = SW'(REDUCE_Q);

    logic [SW-1:0] sum0;
    logic [SW-1:0] sum1;

    // sum below 3q, two subtractions bring it below q
    function automatic logic [COEFF_W-1:0] fold_3q(input logic [SW-1:0] s);
        logic [SW-1:0] t;
        t = (s >= Q_S) ? s - Q_S : s;
        t = (t >= Q_S) ? t - Q_S : t;
        return t[COEFF_W-1:0];
    endfunction

    // mask added to share 0, removed from share 1
    assign sum0 = {2'b00, a[0]} + {2'b00, b[0]} + {2'b00, rnd};
    assign sum1 = {2'b00, a[1]} + {2'b00, b[1]} + Q_S - {2'b00, rnd};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res <= '0;
        end else if (zeroize) begin
            res <= '0;
        end else begin
            res[0] <= fold_3q(sum0);
            res[1] <= fold_3q(sum1);
        end
    end

endmodule

`default_nettype wire

// ==== design/masked_pwm.sv ====
/* masked pwm with optional accumulate */

`timescale 1ns/1ps
`default_nettype none

module masked_pwm import masked_pwm_pkg::*; #(
    parameter int unsigned REDUCE_Q = DEFAULT_Q,
    parameter int          COEFF_W  = DEFAULT_COEFF_W
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize,
    input  logic                               accumulate,
    input  logic [NUM_SHARES-1:0][COEFF_W-1:0] u,
    input  logic [NUM_SHARES-1:0][COEFF_W-1:0] v,
    // w arrives already aligned with the product
    input  logic [NUM_SHARES-1:0][COEFF_W-1:0] w,
    input  logic [COEFF_W-1:0]                 rnd_mul,
    input  logic [COEFF_W-1:0]                 rnd_add,
    output logic [NUM_SHARES-1:0][COEFF_W-1:0] res
);

    logic [NUM_SHARES-1:0][COEFF_W-1:0] prod_q;
    logic [NUM_SHARES-1:0][COEFF_W-1:0] w_q;
    logic [NUM_SHARES-1:0][COEFF_W-1:0] add_res;

    mult_if #(.COEFF_W(COEFF_W)) mul ();

    // operands go to the multiplier unregistered
    assign mul.a_share = u;
    assign mul.b_share = v;
    assign mul.refresh = rnd_mul;

    masked_mult #(
        .REDUCE_Q (REDUCE_Q),
        .COEFF_W  (COEFF_W)
    ) i_mult (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .bus     (mul.multiplier)
    );

    // capture product and w together for the adder
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            w_q    <= '0;
        end else if (zeroize) begin
            prod_q <= '0;
            w_q    <= '0;
        end else begin
            prod_q <= mul.prod_share;
            w_q    <= w;
        end
    end

    masked_add #(
        .REDUCE_Q (REDUCE_Q),
        .COEFF_W  (COEFF_W)
    ) i_add (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .a       (prod_q),
        .b       (w_q),
        .rnd     (rnd_add),
        .res     (add_res)
    );

    // multiply mode bypasses capture and adder
    assign res = accumulate ? add_res : mul.prod_share;

endmodule

`default_nettype wire

// ==== design/masked_pwm_top.sv ====
/* masked pwm unit, top level */

`timescale 1ns/1ps
`default_nettype none

module masked_pwm_top import masked_pwm_pkg::*; #(
    parameter int unsigned REDUCE_Q = DEFAULT_Q,
    parameter int          COEFF_W  = DEFAULT_COEFF_W
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize,
    input  logic                               accumulate,
    input  logic                               in_valid,
    input  logic [NUM_SHARES-1:0][COEFF_W-1:0] u_share,
    input  logic [NUM_SHARES-1:0][COEFF_W-1:0] v_share,
    input  logic [NUM_SHARES-1:0][COEFF_W-1:0] w_share,
    input  logic [COEFF_W-1:0]                 rnd_mul,
    input  logic [COEFF_W-1:0]                 rnd_add,
    output logic                               out_valid,
    output logic [NUM_SHARES-1:0][COEFF_W-1:0] res_share
);

    // w meets the product at the capture stage
    localparam int W_DLY  = PWM_LAT;
    // rnd_add meets the captured operands at the adder
    localparam int RA_DLY = PWMA_LAT - ADD_LAT;

    logic [W_DLY-1:0][NUM_SHARES-1:0][COEFF_W-1:0] w_dly;
    logic [RA_DLY-1:0][COEFF_W-1:0]                rnd_add_dly;
    logic [PWMA_LAT-1:0]                           vld_sr;

    // alignment lines and valid pipe, all cleared by zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w_dly       <= '0;
            rnd_add_dly <= '0;
            vld_sr      <= '0;
        end else if (zeroize) begin
            // in-flight ops are dropped here
            w_dly       <= '0;
            rnd_add_dly <= '0;
            vld_sr      <= '0;
        end else begin
            w_dly[0]       <= w_share;
            rnd_add_dly[0] <= rnd_add;
            vld_sr[0]      <= in_valid;
            for (int i = 1; i < W_DLY; i++) begin
                w_dly[i] <= w_dly[i-1];
            end
            for (int i = 1; i < RA_DLY; i++) begin
                rnd_add_dly[i] <= rnd_add_dly[i-1];
            end
            for (int i = 1; i < PWMA_LAT; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
        end
    end

    // tap 4 in multiply mode, tap 6 in accumulate
    assign out_valid = accumulate ? vld_sr[PWMA_LAT-1] : vld_sr[PWM_LAT-1];

    masked_pwm #(
        .REDUCE_Q (REDUCE_Q),
        .COEFF_W  (COEFF_W)
    ) i_pwm (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .accumulate (accumulate),
        .u          (u_share),
        .v          (v_share),
        .w          (w_dly[W_DLY-1]),
        .rnd_mul    (rnd_mul),
        .rnd_add    (rnd_add_dly[RA_DLY-1]),
        .res        (res_share)
    );

endmodule

`default_nettype wire

// ==== tests/masked_pwm_tb.sv ====
/* masked pwm testbench */

`timescale 1ns/1ps
`default_nettype none

module masked_pwm_tb import masked_pwm_pkg::*; ();

    localparam int unsigned Q       = DEFAULT_Q;
    localparam int          CW      = DEFAULT_COEFF_W;
    localparam int          TIMEOUT = 200;

    typedef logic [NUM_SHARES-1:0][CW-1:0] shares_t;

    logic          clk;
    logic          reset_n;
    logic          zeroize;
    logic          accumulate;
    logic          in_valid;
    shares_t       u_share;
    shares_t       v_share;
    shares_t       w_share;
    logic [CW-1:0] rnd_mul;
    logic [CW-1:0] rnd_add;
    logic          out_valid;
    shares_t       res_share;

    // expected results and the cycle each op went in
    longint unsigned exp_q[$];
    int              cyc_q[$];
    int              cycle = 0;
    logic [CW-1:0]   last_share0;
    logic [23:0]     lfsr_state;
    longint unsigned got;
    longint unsigned exp_val;
    int              exp_cyc;
    int              lat;

    masked_pwm_top #(
        .REDUCE_Q (Q),
        .COEFF_W  (CW)
    ) i_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .accumulate (accumulate),
        .in_valid   (in_valid),
        .u_share    (u_share),
        .v_share    (v_share),
        .w_share    (w_share),
        .rnd_mul    (rnd_mul),
        .rnd_add    (rnd_add),
        .out_valid  (out_valid),
        .res_share  (res_share)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_test(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // galois lfsr with taps 24 23 22 17
    function automatic logic [23:0] lfsr_step(input logic [23:0] s);
        return (s >> 1) ^ (s[0] ? 24'hE10000 : 24'h000000);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // 23 bits folded below q
    function automatic logic [CW-1:0] rand_coeff();
        logic [31:0] val;
        val = rand_bits(23);
        if (val >= Q) begin
            val = val - Q;
        end
        return val[CW-1:0];
    endfunction

    // recombined shares give u*v (+ w) mod q
    function automatic longint unsigned ref_pwm(input shares_t u, input shares_t v,
                                                input shares_t w, input logic acc);
        longint unsigned uu;
        longint unsigned vv;
        longint unsigned ww;
        uu = (64'(u[0]) + 64'(u[1])) % Q;
        vv = (64'(v[0]) + 64'(v[1])) % Q;
        ww = acc ? (64'(w[0]) + 64'(w[1])) % Q : 64'd0;
        return (uu * vv + ww) % Q;
    endfunction

    // one op per falling edge, expectation queued with its cycle
    task automatic drive_op(input shares_t u, input shares_t v, input shares_t w,
                            input logic [CW-1:0] rm, input logic [CW-1:0] ra);
        @(negedge clk);
        u_share  = u;
        v_share  = v;
        w_share  = w;
        rnd_mul  = rm;
        rnd_add  = ra;
        in_valid = 1'b1;
        exp_q.push_back(ref_pwm(u, v, w, accumulate));
        cyc_q.push_back(cycle);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic send_random();
        shares_t       u;
        shares_t       v;
        shares_t       w;
        logic [CW-1:0] rm;
        logic [CW-1:0] ra;
        for (int s = 0; s < NUM_SHARES; s++) begin
            u[s] = rand_coeff();
            v[s] = rand_coeff();
            w[s] = rand_coeff();
        end
        rm = rand_coeff();
        ra = rand_coeff();
        drive_op(u, v, w, rm, ra);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n == TIMEOUT) begin
                abort_test("timed out waiting for pending results");
            end
            @(negedge clk);
            n++;
        end
    endtask

    // 0, 1 and q-1 on every share
    task automatic corner_ops();
        logic [CW-1:0] c[3];
        shares_t       u;
        shares_t       v;
        shares_t       w;
        c[0] = '0;
        c[1] = CW'(1);
        c[2] = CW'(Q - 1);
        for (int i = 0; i < 81; i++) begin
            u = {c[(i/27)%3], c[(i/9)%3]};
            v = {c[(i/3)%3], c[i%3]};
            w = {c[(i/3)%3], c[2]};
            drive_op(u, v, w, c[i%3], c[2]);
        end
        idle_cycles(1);
    endtask

    // same operands twice with new masks
    task automatic check_fresh();
        shares_t         u;
        shares_t         v;
        shares_t         w;
        logic [CW-1:0]   rm_a;
        logic [CW-1:0]   rm_b;
        logic [CW-1:0]   ra_a;
        logic [CW-1:0]   ra_b;
        logic [CW-1:0]   s_a;
        longint unsigned want;
        longint unsigned diff;
        for (int s = 0; s < NUM_SHARES; s++) begin
            u[s] = rand_coeff();
            v[s] = rand_coeff();
            w[s] = rand_coeff();
        end
        rm_a = rand_coeff();
        ra_a = rand_coeff();
        rm_b = accumulate ? rm_a : rand_coeff();
        ra_b = rand_coeff();
        if (!accumulate && rm_b == rm_a) begin
            rm_b = CW'((64'(rm_a) + 1) % Q);
        end
        if (accumulate && ra_b == ra_a) begin
            ra_b = CW'((64'(ra_a) + 1) % Q);
        end
        // share 0 carries +rnd_mul and gains +rnd_add in the adder
        want = (2*64'(Q) + rm_a - rm_b + (accumulate ? 64'(Q) + ra_a - ra_b : 64'd0)) % Q;
        drive_op(u, v, w, rm_a, ra_a);
        idle_cycles(1);
        wait_drained();
        s_a = last_share0;
        drive_op(u, v, w, rm_b, ra_b);
        idle_cycles(1);
        wait_drained();
        diff = (64'(Q) + s_a - last_share0) % Q;
        assert (diff == want)
            else abort_test($sformatf("Fail at %0t: res_share[0] difference expected %0d, got %0d",
                                      $time, want, diff));
    endtask

    // 0 to 3 idle cycles after each op
    task automatic gapped_stream(input int n);
        for (int i = 0; i < n; i++) begin
            send_random();
            idle_cycles(rand_bits(2));
        end
        idle_cycles(1);
    endtask

    task automatic zeroize_in_flight();
        repeat (3) send_random();
        @(negedge clk);
        in_valid = 1'b0;
        zeroize  = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        // whatever is still queued was caught by the zeroize edge
        exp_q.delete();
        cyc_q.delete();
        idle_cycles(8);
        send_random();
        idle_cycles(1);
        wait_drained();
    endtask

    // mode switch only after a quiet pipeline
    task automatic exercise_mode(input logic acc);
        wait_drained();
        idle_cycles(6);
        accumulate = acc;
        repeat (200) send_random();
        idle_cycles(1);
        corner_ops();
        check_fresh();
        check_fresh();
        gapped_stream(100);
        zeroize_in_flight();
    endtask

    // scoreboard checks one result per out_valid
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (reset_n && out_valid) begin
            assert (exp_q.size() != 0)
                else abort_test("out_valid seen with no operation pending");
            got     = (64'(res_share[0]) + 64'(res_share[1])) % Q;
            exp_val = exp_q.pop_front();
            exp_cyc = cyc_q.pop_front();
            lat     = accumulate ? 6 : 4;
            assert (got == exp_val)
                else abort_test($sformatf("Fail at %0t: res_share expected %0d, got %0d",
                                          $time, exp_val, got));
            assert (cycle - exp_cyc == lat)
                else abort_test($sformatf("Fail at %0t: out_valid latency expected %0d, got %0d",
                                          $time, lat, cycle - exp_cyc));
            last_share0 = res_share[0];
        end
    end

    initial begin
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        accumulate = 1'b0;
        in_valid   = 1'b0;
        u_share    = '0;
        v_share    = '0;
        w_share    = '0;
        rnd_mul    = '0;
        rnd_add    = '0;
        lfsr_state = 24'd62546;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        exercise_mode(1'b0);
        exercise_mode(1'b1);
        wait_drained();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/masked_pwm_pkg.sv
design/mult_if.sv
design/barrett_reduce.sv
design/masked_mult.sv
design/masked_add.sv
design/masked_pwm.sv
design/masked_pwm_top.sv
tests/masked_pwm_tb.sv
